//--- source/packet_pkg.sv
package packet_pkg;

  // --------------------------------------
  // Field widths
  // --------------------------------------

  // One bit per switch port
  localparam int mask_width = 4;

  // Data byte carried by every packet
  localparam int payload_width = 8;

  // --------------------------------------
  // Packet types
  // --------------------------------------

  // Source, target and served masks share this shape
  typedef logic [mask_width-1:0] port_mask_t;

  typedef logic [payload_width-1:0] payload_t;

  // Source in the top nibble, payload in the low byte
  typedef struct packed {
    port_mask_t source;
    port_mask_t target;
    payload_t   payload;
  } packet_t;

  // Target for all ports
  // Also the only target allowed to contain the source bit
  localparam port_mask_t broadcast_mask = '1;

endpackage

//--- source/fabric_pkg.sv
package fabric_pkg;

  // --------------------------------------
  // Fabric dimensions
  // --------------------------------------

  localparam int num_ports = 4;

  // Entries per input FIFO
  localparam int fifo_depth = 8;

  // Bits needed to name one input
  localparam int grant_width = 2;

  typedef logic [grant_width-1:0] grant_t;

  // --------------------------------------
  // Sequencer states
  // --------------------------------------

  typedef enum logic [1:0] {
    st_idle     = 2'b00,
    st_receive  = 2'b01,
    st_route    = 2'b10,
    st_transmit = 2'b11
  } fabric_state_t;

endpackage

//--- source/head_if.sv
interface head_if import packet_pkg::*; ();

  // Head packet held by one ingress queue
  logic       valid;
  packet_t    pkt;
  // Targets still waiting for a copy
  port_mask_t pending;
  // One-cycle pulse per output that took the head
  port_mask_t served;

  // Ingress side
  modport queue (
    output valid, pkt, pending,
    input  served
  );

  // Crossbar side
  modport fabric (
    input  valid, pkt, pending,
    output served
  );

endinterface

//--- source/sync_fifo.sv
module sync_fifo #(
  parameter int width = 16,
  parameter int depth = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic [width-1:0] wr_data,
  input  logic             rd_en,
  output logic [width-1:0] rd_data,
  output logic             full,
  output logic             empty
);

  localparam int ptr_width = $clog2(depth);

  logic [width-1:0]     mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 do_wr;
  logic                 do_rd;

  // Blocked requests are simply dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign empty = (count == '0);
  assign full  = (count == (ptr_width+1)'(depth));

  // Head entry visible without a read cycle
  assign rd_data = mem[rd_ptr];

  // Storage array
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Read plus write keeps the count
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- source/ingress_queue.sv
module ingress_queue import packet_pkg::*, fabric_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  packet_t in_pkt,
  input  logic    receive,
  output logic    busy,
  head_if.queue   head
);

  logic       src_one_hot;
  logic       tgt_ok;
  logic       push;
  logic       pop;
  logic       fifo_empty;
  packet_t    fifo_head;
  logic       head_valid;
  packet_t    head_pkt;
  port_mask_t served_mask;
  logic       head_done;

  // --------------------------------------
  // Ingress check
  // --------------------------------------

  // Nonzero with a single bit
  assign src_one_hot = (in_pkt.source != '0) &&
                       ((in_pkt.source & (in_pkt.source - 1'b1)) == '0);

  // No self target unless broadcast
  assign tgt_ok = (in_pkt.target != '0) &&
                  ((in_pkt.target == broadcast_mask) ||
                   ((in_pkt.target & in_pkt.source) == '0));

  assign push = in_valid && src_one_hot && tgt_ok;

  // Full FIFO drops silently
  sync_fifo #(
    .width ($bits(packet_t)),
    .depth (fifo_depth)
  ) i_sync_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (push),
    .wr_data (in_pkt),
    .rd_en   (pop),
    .rd_data (fifo_head),
    .full    (),
    .empty   (fifo_empty)
  );

  // --------------------------------------
  // Head register
  // --------------------------------------

  // Targets left to serve
  assign head.pending = head_valid ? (head_pkt.target & ~served_mask) : '0;
  assign head.valid   = head_valid;
  assign head.pkt     = head_pkt;

  assign head_done = head_valid && (head.pending == '0);

  // Refill only at the end of a receive cycle
  assign pop = receive && (!head_valid || head_done) && !fifo_empty;

  assign busy = !fifo_empty || head_valid;

  // Head packet capture
  always_ff @(posedge clk) begin
    if (pop) begin
      head_pkt <= fifo_head;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_valid  <= 1'b0;
      served_mask <= '0;
    end else if (pop) begin
      head_valid  <= 1'b1;
      served_mask <= '0;
    end else if (head_done) begin
      // Nothing to refill with
      head_valid  <= 1'b0;
      served_mask <= '0;
    end else begin
      served_mask <= served_mask | head.served;
    end
  end

endmodule

//--- source/fabric_sequencer.sv
module fabric_sequencer import packet_pkg::*, fabric_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  port_mask_t busy,
  output logic       receive,
  output logic       transmit
);

  fabric_state_t state;
  fabric_state_t next_state;
  logic          any_busy;

  assign any_busy = |busy;

  // Round order
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (any_busy) begin
          next_state = st_receive;
        end
      end
      st_receive: next_state = st_route;
      // Settling cycle only
      st_route: next_state = st_transmit;
      st_transmit: begin
        next_state = any_busy ? st_receive : st_idle;
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // One cycle of each phase level per round
  assign receive  = (state == st_receive);
  assign transmit = (state == st_transmit);

endmodule

//--- source/rr_arbiter.sv
module rr_arbiter import packet_pkg::*, fabric_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  port_mask_t req,
  output grant_t     grant
);

  grant_t     ptr;
  port_mask_t rotated;
  grant_t     pick;
  logic       found;

  // Grant follows the request in the same cycle
  always_comb begin
    // Bit 0 of rotated is the input at the pointer
    for (int i = 0; i < num_ports; i++) begin
      rotated[i] = req[(i + int'(ptr)) % num_ports];
    end

    // Lowest set bit wins
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < num_ports; i++) begin
      if (!found && rotated[i]) begin
        pick  = grant_t'(i);
        found = 1'b1;
      end
    end

    // Back to an input index
    grant = '0;
    if (found) begin
      grant = grant_t'((int'(pick) + int'(ptr)) % num_ports);
    end
  end

  // Priority moves on every clock regardless of traffic
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else begin
      ptr <= (ptr == grant_t'(num_ports - 1)) ? '0 : ptr + 1'b1;
    end
  end

endmodule

//--- source/crossbar.sv
module crossbar import packet_pkg::*, fabric_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       transmit,
  head_if.fabric     heads [num_ports],
  output port_mask_t out_valid,
  output packet_t    out_pkt [num_ports]
);

  logic       head_valid   [num_ports];
  packet_t    head_pkt     [num_ports];
  port_mask_t head_pending [num_ports];
  port_mask_t served       [num_ports];
  port_mask_t req          [num_ports];
  grant_t     grant        [num_ports];

  // --------------------------------------
  // Head access
  // --------------------------------------

  for (genvar i = 0; i < num_ports; i++) begin : g_head
    assign head_valid[i]   = heads[i].valid;
    assign head_pkt[i]     = heads[i].pkt;
    assign head_pending[i] = heads[i].pending;
    assign heads[i].served = served[i];
  end

  // --------------------------------------
  // Per output arbitration
  // --------------------------------------

  for (genvar o = 0; o < num_ports; o++) begin : g_out
    // Inputs still owing this output a copy
    for (genvar i = 0; i < num_ports; i++) begin : g_req
      assign req[o][i] = head_valid[i] && head_pending[i][o];
    end

    rr_arbiter i_rr_arbiter (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req[o]),
      .grant (grant[o])
    );

    // Drive only in transmit
    assign out_valid[o] = transmit && req[o][grant[o]];
    assign out_pkt[o]   = out_valid[o] ? head_pkt[grant[o]] : '0;
  end

  // Served pulses go back to the granted head
  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      for (int o = 0; o < num_ports; o++) begin
        served[i][o] = out_valid[o] && (grant[o] == grant_t'(i));
      end
    end
  end

endmodule

//--- source/switch_4port.sv
module switch_4port import packet_pkg::*, fabric_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  port_mask_t in_valid,
  input  port_mask_t in_source  [num_ports],
  input  port_mask_t in_target  [num_ports],
  input  payload_t   in_data    [num_ports],
  output port_mask_t out_valid,
  output port_mask_t out_source [num_ports],
  output port_mask_t out_target [num_ports],
  output payload_t   out_data   [num_ports]
);

  packet_t    in_pkt  [num_ports];
  packet_t    out_pkt [num_ports];
  port_mask_t busy;
  logic       receive;
  logic       transmit;

  head_if heads [num_ports] ();

  // --------------------------------------
  // Ingress side
  // --------------------------------------

  for (genvar i = 0; i < num_ports; i++) begin : g_in
    assign in_pkt[i] = '{source: in_source[i], target: in_target[i], payload: in_data[i]};

    ingress_queue i_ingress_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid[i]),
      .in_pkt   (in_pkt[i]),
      .receive  (receive),
      .busy     (busy[i]),
      .head     (heads[i])
    );
  end

  // Round pacing
  fabric_sequencer i_fabric_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (busy),
    .receive  (receive),
    .transmit (transmit)
  );

  // --------------------------------------
  // Egress side
  // --------------------------------------

  crossbar i_crossbar (
    .clk       (clk),
    .rst_n     (rst_n),
    .transmit  (transmit),
    .heads     (heads),
    .out_valid (out_valid),
    .out_pkt   (out_pkt)
  );

  // Zero fields come through from the crossbar
  for (genvar o = 0; o < num_ports; o++) begin : g_unpack
    assign out_source[o] = out_pkt[o].source;
    assign out_target[o] = out_pkt[o].target;
    assign out_data[o]   = out_pkt[o].payload;
  end

endmodule

//--- tests/switch_4port_tb.sv
module switch_4port_tb
  import packet_pkg::*, fabric_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Cycles allowed for all expected copies to arrive
  localparam int drain_limit = 400;
  localparam int quiet_cycles = 12;

  logic       clk;
  logic       rst_n;
  port_mask_t in_valid;
  port_mask_t in_source  [num_ports];
  port_mask_t in_target  [num_ports];
  payload_t   in_data    [num_ports];
  port_mask_t out_valid;
  port_mask_t out_source [num_ports];
  port_mask_t out_target [num_ports];
  payload_t   out_data   [num_ports];

  // Scoreboard by output and data byte
  int         expected [num_ports][256];
  int         outstanding;
  logic       used     [256];
  port_mask_t sent_src [256];
  port_mask_t sent_tgt [256];
  port_mask_t last_valid;
  int         t;

  switch_4port i_switch_4port (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_source  (in_source),
    .in_target  (in_target),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_source (out_source),
    .out_target (out_target),
    .out_data   (out_data)
  );

  always #5 clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic report_mismatch(input string what);
    $display("Test failed");
    $display("mismatch at %0t ns: %s", $time, what);
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Test failed");
    $fatal(1, "no progress after %0d cycles at %0t ns, %s", drain_limit, $time, what);
  endtask

  // Ingress acceptance rule
  function automatic logic rule_ok(input port_mask_t src, input port_mask_t tgt);
    return ($countones(src) == 1) && (tgt != '0) &&
           ((tgt == broadcast_mask) || ((tgt & src) == '0));
  endfunction

  function automatic port_mask_t one_hot(input int idx);
    return port_mask_t'(1 << idx);
  endfunction

  function automatic int pick_port();
    return int'($urandom_range(3));
  endfunction

  // Unused data byte so every packet is traceable
  function automatic payload_t fresh_byte();
    payload_t b;
    b = payload_t'($urandom_range(255));
    while (used[b]) begin
      b = b + 8'd1;
    end
    used[b] = 1'b1;
    return b;
  endfunction

  // Drives one port for the coming edge and books its copies
  task automatic load_port(input int port, input port_mask_t src, input port_mask_t tgt);
    payload_t b;
    b = fresh_byte();
    in_valid[port]  <= 1'b1;
    in_source[port] <= src;
    in_target[port] <= tgt;
    in_data[port]   <= b;
    sent_src[b] = src;
    sent_tgt[b] = tgt;
    if (rule_ok(src, tgt)) begin
      for (int o = 0; o < num_ports; o++) begin
        if (tgt[o]) begin
          expected[o][b] = expected[o][b] + 1;
          outstanding = outstanding + 1;
        end
      end
    end
  endtask

  task automatic next_beat();
    @(posedge clk);
    in_valid <= '0;
  endtask

  task automatic wait_drain();
    int cycles;
    next_beat();
    cycles = 0;
    while (outstanding != 0) begin
      if (cycles >= drain_limit) begin
        report_timeout("copies still missing on the outputs");
      end
      @(posedge clk);
      cycles++;
    end
    // Stray copies would show here
    for (int c = 0; c < quiet_cycles; c++) begin
      @(negedge clk);
      assert (out_valid == '0) else report_mismatch("out_valid high after drain");
    end
  endtask

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------

  task automatic check_output(input int o);
    payload_t b;
    b = out_data[o];
    if (out_valid[o]) begin
      assert (!last_valid[o])
        else report_mismatch($sformatf("out_valid[%0d] high two cycles in a row", o));
      assert (expected[o][b] > 0)
        else report_mismatch($sformatf("output %0d carries unexpected byte %h", o, b));
      assert (out_source[o] == sent_src[b] && out_target[o] == sent_tgt[b])
        else report_mismatch($sformatf("output %0d header wrong for byte %h", o, b));
      expected[o][b] = expected[o][b] - 1;
      outstanding = outstanding - 1;
    end else begin
      assert (out_source[o] == '0 && out_target[o] == '0 && out_data[o] == '0)
        else report_mismatch($sformatf("output %0d fields not zero while idle", o));
    end
  endtask

  // Sampled on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (out_valid == '0) else report_mismatch("out_valid high during reset");
    end else begin
      for (int o = 0; o < num_ports; o++) begin
        check_output(o);
      end
    end
    last_valid = out_valid;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    void'($urandom(32'h4d21));
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = '0;
    outstanding = 0;
    last_valid = '0;
    for (int i = 0; i < num_ports; i++) begin
      in_source[i] = '0;
      in_target[i] = '0;
      in_data[i] = '0;
    end
    for (int b = 0; b < 256; b++) begin
      used[b] = 1'b0;
      sent_src[b] = '0;
      sent_tgt[b] = '0;
      for (int o = 0; o < num_ports; o++) begin
        expected[o][b] = 0;
      end
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Unicast to any port but the source
    for (int n = 0; n < 8; n++) begin
      next_beat();
      t = pick_port();
      load_port(pick_port(), one_hot(t), one_hot((t + 1 + pick_port() % 3) % num_ports));
    end
    wait_drain();

    // Multicast sets without the source bit
    for (int n = 0; n < 6; n++) begin
      next_beat();
      t = pick_port();
      load_port(pick_port(), one_hot(t), (port_mask_t'($urandom_range(14)) + 4'd1) & ~one_hot(t));
    end
    wait_drain();

    // Broadcast including output 0
    next_beat();
    load_port(0, 4'b0001, broadcast_mask);
    next_beat();
    load_port(pick_port(), one_hot(pick_port()), broadcast_mask);
    wait_drain();

    // Rule breakers followed by one legal packet
    next_beat();
    load_port(0, 4'b0011, 4'b0100);
    next_beat();
    load_port(1, 4'b0000, 4'b0010);
    next_beat();
    load_port(2, 4'b0100, 4'b0000);
    next_beat();
    load_port(3, 4'b0010, 4'b0110);
    next_beat();
    load_port(0, 4'b1001, broadcast_mask);
    next_beat();
    load_port(1, 4'b0001, 4'b1000);
    wait_drain();

    // Two packets per input to one output
    t = pick_port();
    repeat (2) begin
      next_beat();
      for (int p = 0; p < num_ports; p++) begin
        load_port(p, one_hot((t + 1 + pick_port() % 3) % num_ports), one_hot(t));
      end
    end
    wait_drain();

    // Random legal and illegal packets
    for (int n = 0; n < 8; n++) begin
      next_beat();
      load_port(pick_port(), port_mask_t'($urandom_range(15)), port_mask_t'($urandom_range(15)));
    end
    wait_drain();

    $display("Test passed");
    $finish;
  end

endmodule

//--- filelist.f
source/packet_pkg.sv
source/fabric_pkg.sv
source/head_if.sv
source/sync_fifo.sv
source/ingress_queue.sv
source/fabric_sequencer.sv
source/rr_arbiter.sv
source/crossbar.sv
source/switch_4port.sv
tests/switch_4port_tb.sv

//--- Makefile
# Verilator flow for the 4-port switch

VERILATOR ?= verilator
TOP       ?= switch_4port_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
